/* verilog.f */
hdl/fetch_pkg.sv
hdl/fetch_mem_if.sv
hdl/instr_realign.sv
hdl/imem_array.sv
hdl/fetch_regs.sv
hdl/fetch_seq.sv
hdl/fetch_top.sv
sim/tb_fetch.sv

/* sim/tb_fetch.sv */
/* Directed testbench for the fetch front end. Loads programs over AXI4-Lite and
   checks the instruction stream against a halfword walker over a program model */
`timescale 1ns/100ps
`default_nettype none

module tb_fetch import fetch_pkg::*;;

    localparam int exp_items = 85;
    localparam int watchdog_cycles = exp_items * 200 + 4000;
    // Bit k set makes instruction k of the mixed program compressed
    localparam logic [31:0] mix_mask = 32'h4532_5169;

    logic              clk;
    logic              rst_n;
    logic [xlen-1:0]   awaddr;
    logic              awvalid;
    logic              awready;
    logic [xlen-1:0]   wdata;
    logic [xlen/8-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [xlen-1:0]   araddr;
    logic              arvalid;
    logic              arready;
    logic [xlen-1:0]   rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic              instr_ready;
    logic              instr_valid;
    logic [xlen-1:0]   instr;
    logic [xlen-1:0]   instr_pc;
    logic              instr_compressed;

    // Program model that mirrors every word loaded into the DUT
    logic [xlen-1:0] prog [imem_words];
    logic [31:0]     lfsr;
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] redirect_target;
    logic            redirect_armed;
    logic            kill_sent;
    logic            stalled_prev;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_instr;
    int              handshakes;

    fetch_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the stream or an AXI response stopped making progress");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] expected);
        $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string what);
        $display("error at time %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic next_lfsr_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [15:0] model_half(input logic [xlen-1:0] pc);
        logic [xlen-1:0] w;
        w = prog[pc[imem_aw+1:2]];
        return pc[1] ? w[31:16] : w[15:0];
    endfunction

    // Reference decode of one instruction from the model halfwords
    task automatic walk_step(input logic [xlen-1:0] pc, output logic [xlen-1:0] e_instr,
                             output logic e_comp, output logic [xlen-1:0] next_pc);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = model_half(pc);
        hi = model_half(pc + 32'd2);
        e_comp = (lo[1:0] != 2'b11);
        e_instr = e_comp ? {16'h0, lo} : {hi, lo};
        next_pc = pc + (e_comp ? 32'd2 : 32'd4);
    endtask

    task automatic axi_write(input logic [reg_aw-1:0] offset, input logic [xlen-1:0] data,
                             input logic [1:0] exp_resp);
        #1;
        awaddr = {{(xlen-reg_aw){1'b0}}, offset};
        awvalid = 1'b1;
        wdata = data;
        wstrb = '1;
        wvalid = 1'b1;
        @(posedge clk);
        while (!(awready && wready)) @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        assert (bresp === exp_resp)
            else report_mismatch("bresp", {30'h0, bresp}, {30'h0, exp_resp});
    endtask

    task automatic axi_read(input logic [reg_aw-1:0] offset, input logic [xlen-1:0] exp_data,
                            input logic [1:0] exp_resp);
        #1;
        araddr = {{(xlen-reg_aw){1'b0}}, offset};
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        assert (rresp === exp_resp)
            else report_mismatch("rresp", {30'h0, rresp}, {30'h0, exp_resp});
        assert (rdata === exp_data) else report_mismatch("rdata", rdata, exp_data);
    endtask

    task automatic build_aligned(input int base_word, input int n_words);
        for (int i = 0; i < n_words; i++) begin
            prog[base_word + i] = {8'(i * 17 + 1), 8'(i), 16'h0513};
        end
    endtask

    // Compressed halfwords push the following full instructions across words
    task automatic build_mixed(input int base_word, input int n_words);
        logic [15:0] hw [$];
        int k;
        k = 0;
        while (hw.size() < 2 * n_words) begin
            if (mix_mask[k % 32] || hw.size() == 2 * n_words - 1) begin
                hw.push_back({8'(k * 7 + 3), 6'(k), 2'(k % 3)});
            end else begin
                hw.push_back({8'(k), 6'h19, 2'b11});
                hw.push_back({8'h5a ^ 8'(k), 8'(k * 3)});
            end
            k++;
        end
        for (int i = 0; i < n_words; i++) begin
            prog[base_word + i] = {hw[2*i+1], hw[2*i]};
        end
    endtask

    task automatic load_program(input int base_word, input int n_words);
        axi_write(reg_load_addr, base_word, axi_okay);
        for (int i = 0; i < n_words; i++) begin
            axi_write(reg_load_data, prog[base_word + i], axi_okay);
        end
    endtask

    task automatic check_item();
        logic [xlen-1:0] e_instr;
        logic            e_comp;
        logic [xlen-1:0] e_next;
        // Past the kill cycle only the new start PC may follow
        if (redirect_armed && kill_sent) begin
            exp_pc = redirect_target;
            redirect_armed = 1'b0;
        end
        walk_step(exp_pc, e_instr, e_comp, e_next);
        assert (instr_pc === exp_pc) else report_mismatch("instr_pc", instr_pc, exp_pc);
        assert (instr === e_instr) else report_mismatch("instr", instr, e_instr);
        assert (instr_compressed === e_comp)
            else report_mismatch("instr_compressed", {31'h0, instr_compressed}, {31'h0, e_comp});
        exp_pc = e_next;
        handshakes++;
    endtask

    // One sink cycle started right after a rising edge
    task automatic sink_step(input logic ready_val);
        #1 instr_ready = ready_val;
        @(posedge clk);
        if (stalled_prev && instr_valid) begin
            assert (instr_pc === held_pc) else report_mismatch("instr_pc", instr_pc, held_pc);
            assert (instr === held_instr) else report_mismatch("instr", instr, held_instr);
        end
        if (instr_valid && instr_ready) begin
            check_item();
        end
        stalled_prev = instr_valid && !instr_ready;
        held_pc = instr_pc;
        held_instr = instr;
    endtask

    task automatic expect_stream(input logic [xlen-1:0] start_pc, input int n,
                                 input logic random_ready);
        int target;
        target = handshakes + n;
        exp_pc = start_pc;
        stalled_prev = 1'b0;
        while (handshakes < target) begin
            if (random_ready) begin
                sink_step(next_lfsr_bit());
            end else begin
                sink_step(1'b1);
            end
        end
        #1 instr_ready = 1'b0;
    endtask

    task automatic check_registers();
        axi_read(reg_ctrl, 32'h0, axi_okay);
        axi_read(reg_start_pc, 32'h0, axi_okay);
        axi_read(reg_load_addr, 32'h0, axi_okay);
        axi_read(reg_count, 32'h0, axi_okay);
        axi_read(reg_load_data, 32'h0, axi_slverr);
        axi_write(reg_start_pc, 32'h0000_0124, axi_okay);
        axi_read(reg_start_pc, 32'h0000_0124, axi_okay);
        axi_write(reg_count, 32'h0000_0055, axi_slverr);
        axi_read(reg_count, 32'h0, axi_okay);
        axi_read(8'h14, 32'h0, axi_slverr);
    endtask

    task automatic aligned_stream();
        build_aligned(0, 16);
        load_program(0, 16);
        axi_write(reg_start_pc, 32'h0, axi_okay);
        axi_write(reg_ctrl, 32'h1, axi_okay);
        expect_stream(32'h0, 12, 1'b0);
        axi_write(reg_ctrl, 32'h0, axi_okay);
    endtask

    task automatic mixed_stream(input logic random_ready);
        axi_write(reg_start_pc, 32'h80, axi_okay);
        axi_write(reg_ctrl, 32'h1, axi_okay);
        expect_stream(32'h80, 24, random_ready);
        axi_write(reg_ctrl, 32'h0, axi_okay);
    endtask

    // Redirect to an odd halfword PC while the stream runs forward from 0xA0
    task automatic redirect_midstream();
        axi_write(reg_start_pc, 32'hA0, axi_okay);
        axi_write(reg_ctrl, 32'h1, axi_okay);
        redirect_target = 32'h8A;
        redirect_armed = 1'b1;
        kill_sent = 1'b0;
        fork
            expect_stream(32'hA0, 24, 1'b1);
            begin
                repeat (15) @(posedge clk);
                axi_write(reg_start_pc, 32'h8A, axi_okay);
                #1 kill_sent = 1'b1;
            end
        join
        assert (!redirect_armed) else report_failure("stream never continued at the new start PC");
        axi_write(reg_ctrl, 32'h0, axi_okay);
    endtask

    task automatic delivered_count();
        stalled_prev = 1'b0;
        repeat (20) sink_step(1'b1);
        #1 instr_ready = 1'b0;
        axi_read(reg_count, handshakes, axi_okay);
    endtask

    initial begin
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        instr_ready = 1'b0;
        lfsr = 32'h7639d77c;
        handshakes = 0;
        redirect_armed = 1'b0;
        kill_sent = 1'b0;
        stalled_prev = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        check_registers();
        aligned_stream();
        build_mixed(32, 32);
        load_program(32, 32);
        mixed_stream(1'b0);
        mixed_stream(1'b1);
        redirect_midstream();
        delivered_count();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
/* Top of the fetch front end. AXI4-Lite control on one side,
   the fetched instruction stream on the other */
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [xlen-1:0]    awaddr,
    input  wire                awvalid,
    output logic               awready,
    input  wire  [xlen-1:0]    wdata,
    input  wire  [xlen/8-1:0]  wstrb,
    input  wire                wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  wire                bready,
    input  wire  [xlen-1:0]    araddr,
    input  wire                arvalid,
    output logic               arready,
    output logic [xlen-1:0]    rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  wire                rready,
    input  wire                instr_ready,
    output logic               instr_valid,
    output logic [xlen-1:0]    instr,
    output logic [xlen-1:0]    instr_pc,
    output logic               instr_compressed
);

    logic               fetch_en;
    logic               redirect;
    logic [xlen-1:0]    redirect_pc;
    logic               load_we;
    logic [imem_aw-1:0] load_addr;
    logic [xlen-1:0]    load_data;
    logic               deliver_pulse;

    // Sequencer to realigner, realigner to memory
    fetch_mem_if seq_ch ();
    fetch_mem_if mem_ch ();

    fetch_regs regs_i (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .deliver_pulse, .fetch_en, .redirect, .redirect_pc,
        .load_we, .load_addr, .load_data
    );

    fetch_seq seq_i (
        .clk, .rst_n, .fetch_en, .redirect, .redirect_pc, .instr_ready,
        .deliver_pulse, .seq_ch (seq_ch.requester),
        .instr_valid, .instr, .instr_pc, .instr_compressed
    );

    instr_realign realign_i (
        .clk, .rst_n,
        .seq_ch (seq_ch.responder),
        .mem_ch (mem_ch.requester)
    );

    imem_array imem_i (
        .clk, .rst_n, .load_we, .load_addr, .load_data,
        .mem_ch (mem_ch.responder)
    );

endmodule

`default_nettype wire

/* hdl/fetch_seq.sv */
/* Fetch PC sequencer. Requests instructions through the realigner, marks
   compressed ones and hands them out on a valid/ready stream */
`timescale 1ns/100ps
`default_nettype none

module fetch_seq import fetch_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              fetch_en,
    input  wire              redirect,
    input  wire [xlen-1:0]   redirect_pc,
    input  wire              instr_ready,
    output logic             deliver_pulse,
    fetch_mem_if.requester   seq_ch,
    output logic             instr_valid,
    output logic [xlen-1:0]  instr,
    output logic [xlen-1:0]  instr_pc,
    output logic             instr_compressed
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic            taken;
    fetch_word_u     word;

    assign word = seq_ch.rdata;

    // At an odd halfword PC the realigner has already moved the
    // upper halfword down, so the low halfword is always the one to decode
    assign instr_compressed = (word.hw.lower[1:0] != 2'b11);
    assign instr = instr_compressed ? {{(xlen/2){1'b0}}, word.hw.lower} : word.word;
    assign instr_pc = pc;

    // Word in flight at a kill is dropped
    assign instr_valid   = seq_ch.ack & ~redirect;
    assign taken         = instr_valid & instr_ready;
    assign deliver_pulse = taken;

    assign pc_next = pc + (instr_compressed ? xlen'(2) : xlen'(4));

    assign seq_ch.req   = fetch_en;
    assign seq_ch.kill  = redirect;
    // Back-pressure freezes realigner and memory
    assign seq_ch.stall = instr_valid & ~instr_ready;

    // Next address goes out on the handshake edge so the memory
    // starts the following fetch at once
    assign seq_ch.addr = redirect ? redirect_pc : (taken ? pc_next : pc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= seq_ch.addr;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_regs.sv */
/* AXI4-Lite register block for the fetch front end: enable, start PC redirect,
   program load window into the instruction memory and a delivered count */
`timescale 1ns/100ps
`default_nettype none

module fetch_regs import fetch_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [xlen-1:0]     awaddr,
    input  wire                 awvalid,
    output logic                awready,
    input  wire  [xlen-1:0]     wdata,
    input  wire  [xlen/8-1:0]   wstrb,
    input  wire                 wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  wire                 bready,
    input  wire  [xlen-1:0]     araddr,
    input  wire                 arvalid,
    output logic                arready,
    output logic [xlen-1:0]     rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  wire                 rready,
    input  wire                 deliver_pulse,
    output logic                fetch_en,
    output logic                redirect,
    output logic [xlen-1:0]     redirect_pc,
    output logic                load_we,
    output logic [imem_aw-1:0]  load_addr,
    output logic [xlen-1:0]     load_data
);

    logic              wr_en;
    logic              rd_en;
    logic              wr_err;
    logic [reg_aw-1:0] wr_off;
    logic [reg_aw-1:0] rd_off;
    logic [xlen-1:0]   wr_old;
    logic [xlen-1:0]   wr_val;
    logic [xlen-1:0]   rd_val;
    logic              rd_err;
    logic [xlen-1:0]   count;

    function automatic logic [xlen-1:0] strb_merge(input logic [xlen-1:0]   old_val,
                                                   input logic [xlen-1:0]   new_val,
                                                   input logic [xlen/8-1:0] strb);
        logic [xlen-1:0] res;
        res = old_val;
        for (int b = 0; b < xlen / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // AW and W are taken together
    assign wr_en   = awvalid & wvalid & ~bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;
    assign rd_en   = arvalid & ~rvalid;
    assign arready = rd_en;
    assign wr_off  = awaddr[reg_aw-1:0];
    assign rd_off  = araddr[reg_aw-1:0];

    always_comb begin
        wr_err = 1'b0;
        case (wr_off)
            reg_ctrl:      wr_old = {{(xlen-1){1'b0}}, fetch_en};
            reg_start_pc:  wr_old = redirect_pc;
            reg_load_addr: wr_old = {{(xlen-imem_aw){1'b0}}, load_addr};
            reg_load_data: wr_old = load_data;
            default: begin
                wr_old = '0;
                wr_err = 1'b1;
            end
        endcase
        wr_val = strb_merge(wr_old, wdata, wstrb);
    end

    always_comb begin
        rd_err = 1'b0;
        case (rd_off)
            reg_ctrl:      rd_val = {{(xlen-1){1'b0}}, fetch_en};
            reg_start_pc:  rd_val = redirect_pc;
            reg_load_addr: rd_val = {{(xlen-imem_aw){1'b0}}, load_addr};
            reg_count:     rd_val = count;
            // Load data is write only
            default: begin
                rd_val = '0;
                rd_err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_en    <= 1'b0;
            redirect    <= 1'b0;
            redirect_pc <= '0;
            load_we     <= 1'b0;
            load_addr   <= '0;
            count       <= '0;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
        end else begin
            redirect <= 1'b0;
            load_we  <= 1'b0;
            // Step the load index after each stored word
            if (load_we) begin
                load_addr <= load_addr + 1'b1;
            end
            if (deliver_pulse) begin
                count <= count + 1'b1;
            end
            if (wr_en) begin
                bvalid <= 1'b1;
                case (wr_off)
                    reg_ctrl:      fetch_en <= wr_val[0];
                    reg_start_pc: begin
                        redirect_pc <= wr_val;
                        redirect    <= 1'b1;
                    end
                    reg_load_addr: load_addr <= wr_val[imem_aw-1:0];
                    reg_load_data: load_we <= 1'b1;
                    default: ;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response and data payloads
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bresp <= wr_err ? axi_slverr : axi_okay;
            if (wr_off == reg_load_data) begin
                load_data <= wr_val;
            end
        end
        if (rd_en) begin
            rdata <= rd_val;
            rresp <= rd_err ? axi_slverr : axi_okay;
        end
    end

endmodule

`default_nettype wire

/* hdl/imem_array.sv */
/* Synchronous instruction word memory standing in for the instruction cache.
   Acks each request one cycle later and takes program words on a load port */
`timescale 1ns/100ps
`default_nettype none

module imem_array import fetch_pkg::*; (
    input wire                clk,
    input wire                rst_n,
    input wire                load_we,
    input wire [imem_aw-1:0]  load_addr,
    input wire [xlen-1:0]     load_data,
    fetch_mem_if.responder    mem_ch
);

    logic [xlen-1:0]    mem [imem_words];
    logic [imem_aw-1:0] rd_idx;

    // Word index, byte offset and upper address bits ignored
    assign rd_idx = mem_ch.addr[imem_aw+1:2];

    // Load port, one word per cycle
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    // Read data sampled on the request edge, frozen during stall
    always_ff @(posedge clk) begin
        if (!mem_ch.stall) begin
            mem_ch.rdata <= mem[rd_idx];
        end
    end

    // Kill drops the access in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ch.ack <= 1'b0;
        end else if (mem_ch.kill) begin
            mem_ch.ack <= 1'b0;
        end else if (!mem_ch.stall) begin
            mem_ch.ack <= mem_ch.req;
        end
    end

endmodule

`default_nettype wire

/* hdl/instr_realign.sv */
/* Realigner between fetch sequencer and instruction memory. Joins 32-bit
   instructions that straddle a word boundary with a second access at addr + 4 */
`timescale 1ns/100ps
`default_nettype none

module instr_realign import fetch_pkg::*; (
    input wire             clk,
    input wire             rst_n,
    fetch_mem_if.responder seq_ch,
    fetch_mem_if.requester mem_ch
);

    logic [1:0]        state;
    logic [1:0]        state_nxt;
    logic              ack_en;
    logic              conct_en;
    logic              pc_p4_en;
    logic              accepted;
    logic [xlen/2-1:0] upper_buf;
    fetch_word_u       mem_word;
    fetch_word_u       spliced;

    assign mem_word = mem_ch.rdata;
    assign accepted = mem_ch.ack & ~seq_ch.stall;

    // Buffered halfword goes low, new lower halfword goes high
    always_comb begin
        spliced.hw.upper = mem_word.hw.lower;
        spliced.hw.lower = upper_buf;
    end

    // Control passes straight through to memory
    assign mem_ch.req   = seq_ch.req;
    assign mem_ch.kill  = seq_ch.kill;
    assign mem_ch.stall = seq_ch.stall;
    assign mem_ch.addr  = (pc_p4_en & ~seq_ch.kill) ? seq_ch.addr + xlen'(4) : seq_ch.addr;

    assign seq_ch.ack   = ack_en & mem_ch.ack;
    assign seq_ch.rdata = conct_en ? spliced.word : mem_word.word;

    // Keep the upper halfword of every accepted word
    always_ff @(posedge clk) begin
        if (accepted) begin
            upper_buf <= mem_word.hw.upper;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rl_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        ack_en    = 1'b1;
        conct_en  = 1'b0;
        pc_p4_en  = 1'b0;
        case (state)
            rl_idle: begin
                // Hold while a stalled word waits on the stream
                if (!(mem_ch.ack && seq_ch.stall) && seq_ch.addr[1]) begin
                    state_nxt = rl_mis_first;
                end
            end
            rl_mis_first: begin
                // First word only fills the buffer
                ack_en   = 1'b0;
                conct_en = 1'b1;
                if (seq_ch.kill) begin
                    state_nxt = seq_ch.addr[1] ? rl_mis_first : rl_idle;
                end else if (accepted) begin
                    pc_p4_en  = 1'b1;
                    state_nxt = rl_mis_ack;
                end
            end
            rl_mis_ack: begin
                conct_en = 1'b1;
                // Second word access stays at addr + 4 until it is taken
                pc_p4_en = 1'b1;
                if (seq_ch.kill) begin
                    state_nxt = seq_ch.addr[1] ? rl_mis_first : rl_idle;
                end else if (accepted) begin
                    // Next PC still odd, the buffer already holds its low half
                    pc_p4_en  = seq_ch.addr[1];
                    state_nxt = seq_ch.addr[1] ? rl_mis_ack : rl_idle;
                end
            end
            default: begin
                state_nxt = rl_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/fetch_mem_if.sv */
/* Request/acknowledge channel between a fetch requester and a word memory,
   used once from sequencer to realigner and once from realigner to memory */
`timescale 1ns/100ps
`default_nettype none

interface fetch_mem_if import fetch_pkg::*; ();

    // Requester side
    logic            req;
    logic [xlen-1:0] addr;
    logic            kill;
    logic            stall;

    // Responder side, ack one cycle after the request
    logic            ack;
    logic [xlen-1:0] rdata;

    modport requester (
        output req,
        output addr,
        output kill,
        output stall,
        input  ack,
        input  rdata
    );

    modport responder (
        input  req,
        input  addr,
        input  kill,
        input  stall,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

/* hdl/fetch_pkg.sv */
/* Widths, register map, realigner state codes and the fetch word layout
   shared by every block of the instruction fetch front end */
`default_nettype none

package fetch_pkg;

    // Datapath and byte address width
    localparam int xlen = 32;

    // Instruction memory depth in words, 1 KB of byte address space
    localparam int imem_words = 256;
    localparam int imem_aw = $clog2(imem_words);

    // AXI4-Lite register map, byte offsets
    localparam int reg_aw = 8;
    localparam logic [reg_aw-1:0] reg_ctrl      = 8'h00;
    localparam logic [reg_aw-1:0] reg_start_pc  = 8'h04;
    localparam logic [reg_aw-1:0] reg_load_addr = 8'h08;
    localparam logic [reg_aw-1:0] reg_load_data = 8'h0C;
    localparam logic [reg_aw-1:0] reg_count     = 8'h10;

    // AXI response codes
    localparam logic [1:0] axi_okay   = 2'b00;
    localparam logic [1:0] axi_slverr = 2'b10;

    // Realigner states
    localparam logic [1:0] rl_idle      = 2'b00;
    localparam logic [1:0] rl_mis_first = 2'b01;
    localparam logic [1:0] rl_mis_ack   = 2'b10;

    // One memory word, seen whole or as two halfwords
    typedef union packed {
        logic [xlen-1:0] word;
        struct packed {
            logic [xlen/2-1:0] upper;
            logic [xlen/2-1:0] lower;
        } hw;
    } fetch_word_u;

endpackage

`default_nettype wire
